// ==== src/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address layout: tag | index | block offset | byte offset
`define DCACHE_WORD_W      32
`define DCACHE_BYTOFF_W    2
`define DCACHE_BLKOFF_W    1
`define DCACHE_IDX_W       3
`define DCACHE_SETS        8
`define DCACHE_TAG_W       26

// flush walk covers two ways, eight sets, two words
`define DCACHE_FLUSH_SLOTS 32
// one extra bit so the counter can sit at the end value
`define DCACHE_FLUSH_W     6

`endif

// ==== src/dcache_pkg.sv ====
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DCACHE_WORD_W-1:0]  word_t;
    typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
    typedef logic [`DCACHE_IDX_W-1:0]   idx_t;
    typedef logic [`DCACHE_FLUSH_W-1:0] flush_slot_t;

    // request address as seen by the cache
    typedef struct packed {
        tag_t                         tag;
        idx_t                         idx;
        logic [`DCACHE_BLKOFF_W-1:0]  blkoff;
        logic [`DCACHE_BYTOFF_W-1:0]  bytoff;
    } dcache_addr_t;

    // one block of one way
    typedef struct packed {
        word_t word_one;
        word_t word_two;
        tag_t  tag;
        logic  dirty;
        logic  valid;
    } dcache_line_t;

    // datapath side request, held until dhit
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } dp_req_t;

    // memory side request, a plain level
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } mem_req_t;

    // way 0 is way one, way 1 is way two
    typedef struct packed {
        logic         hit;
        logic         hit_way;
        logic         victim_way;
        logic         victim_dirty;
        dcache_addr_t addr;
    } lookup_t;

    typedef enum logic [2:0] {
        IDLE,
        WB_ONE,
        WB_TWO,
        FETCH_ONE,
        FETCH_TWO,
        FLUSH
    } ctrl_state_t;

endpackage

// ==== src/dcache_lookup.sv ====
`timescale 1ns/1ns

module dcache_lookup (
    input  dcache_pkg::word_t        addr,
    input  dcache_pkg::dcache_line_t way_one_line,
    input  dcache_pkg::dcache_line_t way_two_line,
    input  logic                     lru,
    output dcache_pkg::lookup_t      look,
    output dcache_pkg::idx_t         set_idx
);

    dcache_pkg::dcache_addr_t split;
    dcache_pkg::dcache_line_t victim_line;
    logic                     match_one;
    logic                     match_two;

    assign split   = addr;
    assign set_idx = split.idx;

    // only valid lines can match
    assign match_one = way_one_line.valid && (way_one_line.tag == split.tag);
    assign match_two = way_two_line.valid && (way_two_line.tag == split.tag);

    // replacement bit names the way to evict next
    assign victim_line = lru ? way_two_line : way_one_line;

    always_comb begin
        look.hit          = match_one || match_two;
        // way one wins if both somehow match
        look.hit_way      = !match_one && match_two;
        look.victim_way   = lru;
        // victim state only matters on a miss
        look.victim_dirty = !look.hit && victim_line.valid && victim_line.dirty;
        look.addr         = split;
    end

endmodule

// ==== src/dcache_array.sv ====
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_array (
    input  logic                     CLK,
    input  logic                     nRST,
    input  dcache_pkg::idx_t         set_idx,
    input  dcache_pkg::flush_slot_t  flush_slot,
    input  logic                     write_hit,
    input  logic                     fill,
    input  dcache_pkg::lookup_t      look,
    input  dcache_pkg::word_t        store,
    input  dcache_pkg::dcache_line_t fill_line,
    output dcache_pkg::dcache_line_t way_one_line,
    output dcache_pkg::dcache_line_t way_two_line,
    output dcache_pkg::dcache_line_t flush_line,
    output logic                     lru
);

    // line payload per way, index 0 is way one
    dcache_pkg::dcache_line_t lines [2][`DCACHE_SETS];
    logic [1:0][`DCACHE_SETS-1:0] valid_q;
    logic [`DCACHE_SETS-1:0]      lru_q;

    dcache_pkg::idx_t flush_set;
    logic             flush_way;

    // slot bits: set, then word, then way
    assign flush_set = flush_slot[`DCACHE_IDX_W-1:0];
    assign flush_way = flush_slot[`DCACHE_IDX_W+1];

    always_comb begin
        way_one_line       = lines[0][set_idx];
        way_one_line.valid = valid_q[0][set_idx];
        way_two_line       = lines[1][set_idx];
        way_two_line.valid = valid_q[1][set_idx];
        flush_line         = lines[flush_way][flush_set];
        flush_line.valid   = valid_q[flush_way][flush_set];
    end

    assign lru = lru_q[set_idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[look.victim_way][look.addr.idx] <= 1'b1;
        end
    end

    // a held hit keeps pointing the set at the other way
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lru_q <= '0;
        end else if (fill) begin
            lru_q[look.addr.idx] <= !look.victim_way;
        end else if (write_hit || look.hit) begin
            lru_q[look.addr.idx] <= !look.hit_way;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) begin
            lines[look.victim_way][look.addr.idx] <= fill_line;
        end else if (write_hit) begin
            if (look.addr.blkoff[0]) begin
                lines[look.hit_way][look.addr.idx].word_two <= store;
            end else begin
                lines[look.hit_way][look.addr.idx].word_one <= store;
            end
            lines[look.hit_way][look.addr.idx].dirty <= 1'b1;
        end
    end

endmodule

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                     CLK,
    input  logic                     nRST,
    input  dcache_pkg::dp_req_t      dp_req,
    input  logic                     halt,
    input  dcache_pkg::lookup_t      look,
    input  dcache_pkg::dcache_line_t way_one_line,
    input  dcache_pkg::dcache_line_t way_two_line,
    input  logic                     mem_wait,
    input  dcache_pkg::word_t        mem_load,
    output logic                     dhit,
    output dcache_pkg::word_t        dmemload,
    output logic                     write_hit,
    output logic                     fill,
    output dcache_pkg::dcache_line_t fill_line,
    output dcache_pkg::ctrl_state_t  state,
    output logic                     halted
);

    dcache_pkg::ctrl_state_t  next_state;
    dcache_pkg::dcache_line_t hit_line;
    dcache_pkg::word_t        fill_word;
    logic                     req;

    assign req = dp_req.ren || dp_req.wen;

    // read word from the hit way
    assign hit_line = look.hit_way ? way_two_line : way_one_line;
    assign dmemload = look.addr.blkoff[0] ? hit_line.word_two : hit_line.word_one;

    // second word comes straight from memory
    always_comb begin
        fill_line.word_one = fill_word;
        fill_line.word_two = mem_load;
        fill_line.tag      = look.addr.tag;
        fill_line.dirty    = 1'b0;
        fill_line.valid    = 1'b1;
    end

    assign halted = (state == dcache_pkg::FLUSH);

    always_comb begin
        next_state = state;
        dhit       = 1'b0;
        write_hit  = 1'b0;
        fill       = 1'b0;
        case (state)
            dcache_pkg::IDLE: begin
                // halt beats any pending request
                if (halt) begin
                    next_state = dcache_pkg::FLUSH;
                end else if (req) begin
                    if (look.hit) begin
                        dhit      = 1'b1;
                        write_hit = dp_req.wen;
                    end else if (look.victim_dirty) begin
                        next_state = dcache_pkg::WB_ONE;
                    end else begin
                        next_state = dcache_pkg::FETCH_ONE;
                    end
                end
            end
            dcache_pkg::WB_ONE: begin
                if (!mem_wait) begin
                    next_state = dcache_pkg::WB_TWO;
                end
            end
            dcache_pkg::WB_TWO: begin
                if (!mem_wait) begin
                    next_state = dcache_pkg::FETCH_ONE;
                end
            end
            dcache_pkg::FETCH_ONE: begin
                if (!mem_wait) begin
                    next_state = dcache_pkg::FETCH_TWO;
                end
            end
            dcache_pkg::FETCH_TWO: begin
                if (!mem_wait) begin
                    fill       = 1'b1;
                    next_state = dcache_pkg::IDLE;
                end
            end
            dcache_pkg::FLUSH: begin
                next_state = dcache_pkg::FLUSH;
            end
            default: begin
                next_state = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // first fetched word waits here for the second
    always_ff @(posedge CLK) begin
        if (state == dcache_pkg::FETCH_ONE && !mem_wait) begin
            fill_word <= mem_load;
        end
    end

endmodule

// ==== src/dcache_mem_port.sv ====
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_mem_port (
    input  logic                     CLK,
    input  logic                     nRST,
    input  dcache_pkg::ctrl_state_t  state,
    input  dcache_pkg::lookup_t      look,
    input  dcache_pkg::dcache_line_t way_one_line,
    input  dcache_pkg::dcache_line_t way_two_line,
    input  dcache_pkg::dcache_line_t flush_line,
    input  logic                     mem_wait,
    output dcache_pkg::mem_req_t     mem_req,
    output dcache_pkg::flush_slot_t  flush_slot,
    output logic                     flushed
);

    dcache_pkg::dcache_line_t victim_line;
    logic                     slot_live;
    logic                     flush_dirty;
    logic                     flush_word;

    assign victim_line = look.victim_way ? way_two_line : way_one_line;

    assign slot_live   = (flush_slot < `DCACHE_FLUSH_SLOTS);
    assign flush_dirty = slot_live && flush_line.valid && flush_line.dirty;
    assign flush_word  = flush_slot[`DCACHE_IDX_W];
    assign flushed     = (flush_slot == `DCACHE_FLUSH_SLOTS);

    always_comb begin
        mem_req = '0;
        case (state)
            dcache_pkg::WB_ONE,
            dcache_pkg::WB_TWO: begin
                // victim block sits at its own tag in the request set
                mem_req.wen   = 1'b1;
                mem_req.addr  = {victim_line.tag, look.addr.idx,
                                 (state == dcache_pkg::WB_TWO), 2'b00};
                mem_req.store = (state == dcache_pkg::WB_TWO) ? victim_line.word_two
                                                              : victim_line.word_one;
            end
            dcache_pkg::FETCH_ONE,
            dcache_pkg::FETCH_TWO: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {look.addr.tag, look.addr.idx,
                                (state == dcache_pkg::FETCH_TWO), 2'b00};
            end
            dcache_pkg::FLUSH: begin
                if (flush_dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = {flush_line.tag, flush_slot[`DCACHE_IDX_W-1:0],
                                     flush_word, 2'b00};
                    mem_req.store = flush_word ? flush_line.word_two : flush_line.word_one;
                end
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    // clean slots skip ahead, dirty ones wait for memory
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flush_slot <= '0;
        end else if (state == dcache_pkg::FLUSH && slot_live && (!flush_dirty || !mem_wait)) begin
            flush_slot <= flush_slot + 1'b1;
        end
    end

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dcache_pkg::dp_req_t  dp_req,
    input  logic                 halt,
    input  logic                 mem_wait,
    input  dcache_pkg::word_t    mem_load,
    output logic                 dhit,
    output dcache_pkg::word_t    dmemload,
    output dcache_pkg::mem_req_t mem_req,
    output logic                 halted,
    output logic                 flushed
);

    dcache_pkg::lookup_t      look;
    dcache_pkg::idx_t         set_idx;
    dcache_pkg::dcache_line_t way_one_line;
    dcache_pkg::dcache_line_t way_two_line;
    dcache_pkg::dcache_line_t flush_line;
    dcache_pkg::dcache_line_t fill_line;
    dcache_pkg::flush_slot_t  flush_slot;
    dcache_pkg::ctrl_state_t  state;
    logic                     lru;
    logic                     write_hit;
    logic                     fill;

    // input side
    dcache_lookup u_lookup (
        .addr         (dp_req.addr),
        .way_one_line (way_one_line),
        .way_two_line (way_two_line),
        .lru          (lru),
        .look         (look),
        .set_idx      (set_idx)
    );

    dcache_array u_array (
        .CLK          (CLK),
        .nRST         (nRST),
        .set_idx      (set_idx),
        .flush_slot   (flush_slot),
        .write_hit    (write_hit),
        .fill         (fill),
        .look         (look),
        .store        (dp_req.store),
        .fill_line    (fill_line),
        .way_one_line (way_one_line),
        .way_two_line (way_two_line),
        .flush_line   (flush_line),
        .lru          (lru)
    );

    dcache_ctrl u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .dp_req       (dp_req),
        .halt         (halt),
        .look         (look),
        .way_one_line (way_one_line),
        .way_two_line (way_two_line),
        .mem_wait     (mem_wait),
        .mem_load     (mem_load),
        .dhit         (dhit),
        .dmemload     (dmemload),
        .write_hit    (write_hit),
        .fill         (fill),
        .fill_line    (fill_line),
        .state        (state),
        .halted       (halted)
    );

    // output side
    dcache_mem_port u_mem_port (
        .CLK          (CLK),
        .nRST         (nRST),
        .state        (state),
        .look         (look),
        .way_one_line (way_one_line),
        .way_two_line (way_two_line),
        .flush_line   (flush_line),
        .mem_wait     (mem_wait),
        .mem_req      (mem_req),
        .flush_slot   (flush_slot),
        .flushed      (flushed)
    );

endmodule

// ==== sim/dcache_clock_gen.sv ====
`timescale 1ns/1ns

module dcache_clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // reset held low over five rising edges
    initial begin
        nRST = 1'b0;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

// ==== sim/dcache_properties.sv ====
`timescale 1ns/1ns

module dcache_properties (
    input logic                 CLK,
    input logic                 nRST,
    input dcache_pkg::dp_req_t  dp_req,
    input logic                 dhit,
    input dcache_pkg::mem_req_t mem_req,
    input logic                 mem_wait,
    input logic                 halted,
    input logic                 flushed
);

    // raised by any failing property below
    logic failed = 1'b0;
    logic mem_active;

    assign mem_active = mem_req.ren || mem_req.wen;

    one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin
            $error("memory read and write strobes high together");
            failed = 1'b1;
        end

    word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        mem_active |-> (mem_req.addr[1:0] == 2'b00))
        else begin
            $error("memory address has a nonzero byte offset");
            failed = 1'b1;
        end

    hit_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
        dhit |-> (dp_req.ren || dp_req.wen))
        else begin
            $error("dhit high without a datapath strobe");
            failed = 1'b1;
        end

    // memory request is a level while the memory stalls
    req_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_wait && mem_active) |=> $stable(mem_req))
        else begin
            $error("memory request changed while mem_wait was high");
            failed = 1'b1;
        end

    reset_quiet: assert property (@(posedge CLK)
        $rose(nRST) |-> (!mem_active && !dhit && !halted && !flushed))
        else begin
            $error("outputs not quiet in the first cycle after reset");
            failed = 1'b1;
        end

endmodule

// ==== sim/dcache_tb.sv ====
`timescale 1ns/1ns

module dcache_tb;

    localparam int REQ_COUNT     = 400;
    localparam int TIMEOUT_LIMIT = 12000;

    logic                 CLK;
    logic                 nRST;
    dcache_pkg::dp_req_t  dp_req;
    logic                 halt;
    logic                 mem_wait = 1'b1;
    dcache_pkg::word_t    mem_load = '0;
    logic                 dhit;
    dcache_pkg::word_t    dmemload;
    dcache_pkg::mem_req_t mem_req;
    logic                 halted;
    logic                 flushed;

    // memory contents, and the last datapath store per address
    dcache_pkg::word_t mem_q [dcache_pkg::word_t];
    dcache_pkg::word_t shadow_q [dcache_pkg::word_t];
    int unsigned       wait_left = 0;
    int unsigned       cycle_count = 0;
    logic              flush_done = 1'b0;

    dcache_clock_gen u_clock_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    dcache_top u_dut (
        .CLK      (CLK),
        .nRST     (nRST),
        .dp_req   (dp_req),
        .halt     (halt),
        .mem_wait (mem_wait),
        .mem_load (mem_load),
        .dhit     (dhit),
        .dmemload (dmemload),
        .mem_req  (mem_req),
        .halted   (halted),
        .flushed  (flushed)
    );

    bind dcache_top dcache_properties u_props (
        .CLK      (CLK),
        .nRST     (nRST),
        .dp_req   (dp_req),
        .dhit     (dhit),
        .mem_req  (mem_req),
        .mem_wait (mem_wait),
        .halted   (halted),
        .flushed  (flushed)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // unwritten words read as their address under a fixed mask
    function automatic dcache_pkg::word_t memory_word(input dcache_pkg::word_t addr);
        if (mem_q.exists(addr)) begin
            return mem_q[addr];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::word_t addr);
        if (shadow_q.exists(addr)) begin
            return shadow_q[addr];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_LIMIT) begin
            report_failure("timeout: requests and flush did not finish in time");
        end
        if (u_dut.u_props.failed) begin
            report_failure("a bound protocol property failed");
        end
    end

    // memory model, every access stalls one to four cycles
    always @(posedge CLK) begin
        if (mem_req.ren || mem_req.wen) begin
            if (!mem_wait) begin
                if (mem_req.wen) begin
                    assert (mem_req.store == expected_word(mem_req.addr))
                        else report_failure(
                            $sformatf("** Error mem_req.store: got %h expected %h at %h",
                                      mem_req.store, expected_word(mem_req.addr),
                                      mem_req.addr));
                    mem_q[mem_req.addr] = mem_req.store;
                end
                mem_wait  <= 1'b1;
                wait_left <= $urandom_range(3, 0);
            end else if (wait_left == 0) begin
                mem_wait <= 1'b0;
                mem_load <= memory_word(mem_req.addr);
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    // after flushed the cache stays halted and the memory port goes quiet
    always @(posedge CLK) begin
        if (flushed || flush_done) begin
            assert (flushed && halted && !mem_req.ren && !mem_req.wen)
                else report_failure("halted, flushed or a quiet memory port lost after flush");
            flush_done <= 1'b1;
        end
    end

    initial begin
        dcache_pkg::dp_req_t      req;
        dcache_pkg::dcache_addr_t addr;
        void'($urandom(93));
        dp_req = '0;
        halt   = 1'b0;
        wait (nRST);
        @(posedge CLK);
        for (int n = 0; n < REQ_COUNT; n++) begin
            // three tags share each set so misses evict
            addr.tag    = 26'h0001C0 + dcache_pkg::tag_t'($urandom_range(2, 0));
            addr.idx    = dcache_pkg::idx_t'($urandom_range(7, 0));
            addr.blkoff = ($urandom_range(1, 0) == 1);
            addr.bytoff = 2'b00;
            req.wen     = ($urandom_range(1, 0) == 1);
            req.ren     = !req.wen;
            req.addr    = addr;
            req.store   = $urandom();
            dp_req <= req;
            do begin
                @(posedge CLK);
            end while (!dhit);
            if (req.ren) begin
                assert (dmemload == expected_word(req.addr))
                    else report_failure($sformatf("** Error dmemload: got %h expected %h at %h",
                                                  dmemload, expected_word(req.addr), req.addr));
            end else begin
                shadow_q[req.addr] = req.store;
            end
        end
        halt   <= 1'b1;
        dp_req <= '0;
        while (!flushed) begin
            @(posedge CLK);
        end
        repeat (8) @(posedge CLK);
        foreach (shadow_q[a]) begin
            assert (memory_word(a) == shadow_q[a])
                else report_failure($sformatf("** Error memory at %h: got %h expected %h",
                                              a, memory_word(a), shadow_q[a]));
        end
        if (u_dut.u_props.failed) begin
            report_failure("a bound protocol property failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== src.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_lookup.sv
src/dcache_array.sv
src/dcache_ctrl.sv
src/dcache_mem_port.sv
src/dcache_top.sv
sim/dcache_clock_gen.sv
sim/dcache_properties.sv
sim/dcache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module dcache_tb -o dcache_sim
./obj_dir/dcache_sim +verilator+error+limit+10 2>&1 | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
